/* source/dram_pkg.sv */
package dram_pkg;

   // chip geometry
   localparam int ROW_W   = 11;
   localparam int COL_W   = 8;
   localparam int BANK_W  = 2;
   localparam int DQ_W    = 32;
   localparam int MASK_W  = DQ_W / 8;
   localparam int WADDR_W = 30;      // word address, byte address bits 31..2

   // byte address positions of column, row and bank
   localparam int COL_LSB  = 2;
   localparam int ROW_LSB  = 10;
   localparam int BANK_LSB = 21;

   // timing in clk cycles
   localparam int T_RCD     = 2;     // activate to read/write
   localparam int CAS_LAT   = 2;
   localparam int T_WR      = 2;     // write recovery
   localparam int T_RP      = 2;     // precharge
   localparam int T_RFC     = 7;     // refresh cycle
   localparam int INIT_WAIT = 200;   // short power-up wait for simulation

   localparam int REFRESH_INTERVAL = 300;

   // A10 selects auto-precharge on read/write and all banks on precharge
   localparam logic [ROW_W-1:0] A10 = 11'h400;

   // burst length 1, sequential, CAS latency 2
   localparam logic [ROW_W-1:0] MODE_REG = 11'h020;

   // {cs_n, ras_n, cas_n, we_n}
   typedef enum logic [3:0] {
      NOP       = 4'b0111,
      ACTIVE    = 4'b0011,
      READ      = 4'b0101,
      WRITE     = 4'b0100,
      PRECHARGE = 4'b0010,
      REFRESH   = 4'b0001,
      LOAD_MODE = 4'b0000
   } sdram_cmd_e;

   typedef enum logic [2:0] {
      S_WAIT,        // shared delay state
      S_INIT_PRE,
      S_INIT_REF,
      S_INIT_MODE,
      S_IDLE,
      S_RW,          // read or write with auto-precharge
      S_CAPTURE,
      S_DONE
   } seq_state_e;

endpackage

/* source/lsu_pkg.sv */
package lsu_pkg;

   // i_ctrl layout: bits 1..0 size, bit 2 unsigned load
   localparam int CTRL_W            = 3;
   localparam int CTRL_UNSIGNED_BIT = 2;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   typedef enum logic [3:0] {
      IDLE,
      RD_REQ,
      RD_WAIT,
      RD2_REQ,      // second word of a split load
      RD2_WAIT,
      WR_SETUP,
      WR_REQ,
      WR_WAIT,
      WR2_SETUP,    // spill part of a split store
      REF_REQ,
      REF_WAIT,
      DONE
   } lsu_state_e;

endpackage

/* source/mem_if.sv */
`timescale 1ns/1ps

// word-level request channel between access controller and sequencer
interface mem_if;
   logic                         rd;
   logic                         wr;
   logic                         refresh;
   logic [dram_pkg::WADDR_W-1:0] addr;
   logic [dram_pkg::DQ_W-1:0]    wdata;
   logic [dram_pkg::MASK_W-1:0]  mask;     // 1 = write this byte
   logic [dram_pkg::DQ_W-1:0]    rdata;
   logic                         busy;

   modport requester (
      output rd, wr, refresh, addr, wdata, mask,
      input  rdata, busy
   );

   modport responder (
      input  rd, wr, refresh, addr, wdata, mask,
      output rdata, busy
   );
endinterface

/* source/dram_access_ctrl.sv */
`timescale 1ns/1ps

module dram_access_ctrl (
   input  logic                       clk,
   input  logic                       rst_x,
   input  logic                       i_rd_en,
   input  logic                       i_wr_en,
   input  logic [31:0]                i_addr,
   input  logic [31:0]                i_data,
   input  logic [lsu_pkg::CTRL_W-1:0] i_ctrl,
   output logic [31:0]                o_data,
   output logic                       o_stall,
   mem_if.requester                   mem
);

   lsu_pkg::lsu_state_e   state;
   lsu_pkg::access_size_e r_size;
   logic [1:0]            r_off;      // byte offset in the first word
   logic                  r_uns;
   logic                  r_load;
   logic                  r_second;   // second word of a split store
   logic [31:0]           r_sdata;
   logic [31:0]           r_word0;
   logic [31:0]           r_word1;
   logic [31:0]           r_odata;
   logic [8:0]            ref_cnt;
   logic                  ref_due;
   logic                  accept;
   logic                  spill;
   logic [3:0]            size_mask;
   logic [7:0]            mask_pair;
   logic [63:0]           data_pair;
   logic [31:0]           ld_raw;
   logic [31:0]           ld_val;

   assign ref_due = ref_cnt > 9'(dram_pkg::REFRESH_INTERVAL);
   assign accept  = (state == lsu_pkg::IDLE) && !mem.busy && !ref_due && (i_rd_en || i_wr_en);

   // a due refresh holds callers off until it has run
   assign o_stall = (state != lsu_pkg::IDLE) || ref_due;
   assign o_data  = r_odata;

   assign mem.rd      = (state == lsu_pkg::RD_REQ) || (state == lsu_pkg::RD2_REQ);
   assign mem.wr      = state == lsu_pkg::WR_REQ;
   assign mem.refresh = state == lsu_pkg::REF_REQ;

   always_comb begin
      case (r_size)
         lsu_pkg::SIZE_BYTE: size_mask = 4'b0001;
         lsu_pkg::SIZE_HALF: size_mask = 4'b0011;
         default:            size_mask = 4'b1111;
      endcase
   end

   // lanes over two words, upper half goes to the next word
   assign mask_pair = {4'b0000, size_mask} << r_off;
   assign data_pair = {32'd0, r_sdata} << {r_off, 3'b000};
   assign spill     = |mask_pair[7:4];   // word at offset 1..3, half at offset 3

   assign ld_raw = 32'({r_word1, r_word0} >> {r_off, 3'b000});

   always_comb begin
      case (r_size)
         lsu_pkg::SIZE_BYTE:
            ld_val = r_uns ? {24'd0, ld_raw[7:0]} : {{24{ld_raw[7]}}, ld_raw[7:0]};
         lsu_pkg::SIZE_HALF:
            ld_val = r_uns ? {16'd0, ld_raw[15:0]} : {{16{ld_raw[15]}}, ld_raw[15:0]};
         default:
            ld_val = ld_raw;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         state    <= lsu_pkg::IDLE;
         r_load   <= 1'b0;
         r_second <= 1'b0;
         ref_cnt  <= '0;
      end else begin
         if (state == lsu_pkg::REF_WAIT && !mem.busy)
            ref_cnt <= '0;
         else if (!ref_due)
            ref_cnt <= ref_cnt + 1'b1;

         case (state)
            lsu_pkg::IDLE: begin
               if (!mem.busy && ref_due) begin
                  state <= lsu_pkg::REF_REQ;
               end else if (accept) begin
                  state    <= i_rd_en ? lsu_pkg::RD_REQ : lsu_pkg::WR_SETUP;
                  r_load   <= i_rd_en;   // loads win over stores
                  r_second <= 1'b0;
               end
            end
            lsu_pkg::RD_REQ:
               if (mem.busy) state <= lsu_pkg::RD_WAIT;
            lsu_pkg::RD_WAIT:
               if (!mem.busy) state <= spill ? lsu_pkg::RD2_REQ : lsu_pkg::DONE;
            lsu_pkg::RD2_REQ:
               if (mem.busy) state <= lsu_pkg::RD2_WAIT;
            lsu_pkg::RD2_WAIT:
               if (!mem.busy) state <= lsu_pkg::DONE;
            lsu_pkg::WR_SETUP:
               state <= lsu_pkg::WR_REQ;
            lsu_pkg::WR_REQ:
               if (mem.busy) state <= lsu_pkg::WR_WAIT;
            lsu_pkg::WR_WAIT: begin
               if (!mem.busy)
                  state <= (spill && !r_second) ? lsu_pkg::WR2_SETUP : lsu_pkg::DONE;
            end
            lsu_pkg::WR2_SETUP: begin
               r_second <= 1'b1;
               state    <= lsu_pkg::WR_REQ;
            end
            lsu_pkg::REF_REQ:
               if (mem.busy) state <= lsu_pkg::REF_WAIT;
            lsu_pkg::REF_WAIT:
               if (!mem.busy) state <= lsu_pkg::IDLE;
            lsu_pkg::DONE:
               state <= lsu_pkg::IDLE;
            default:
               state <= lsu_pkg::IDLE;
         endcase
      end
   end

   // request payload and load data
   always_ff @(posedge clk) begin
      if (accept) begin
         mem.addr <= i_addr[31:2];
         r_off    <= i_addr[1:0];
         r_size   <= lsu_pkg::access_size_e'(i_ctrl[1:0]);
         r_uns    <= i_ctrl[lsu_pkg::CTRL_UNSIGNED_BIT];
         r_sdata  <= i_data;
      end
      if ((state == lsu_pkg::RD_WAIT && !mem.busy && spill) || state == lsu_pkg::WR2_SETUP)
         mem.addr <= mem.addr + 1'b1;   // next word
      if (state == lsu_pkg::RD_WAIT && !mem.busy)
         r_word0 <= mem.rdata;
      if (state == lsu_pkg::RD2_WAIT && !mem.busy)
         r_word1 <= mem.rdata;
      if (state == lsu_pkg::WR_SETUP) begin
         mem.wdata <= data_pair[31:0];
         mem.mask  <= mask_pair[3:0];
      end
      if (state == lsu_pkg::WR2_SETUP) begin
         mem.wdata <= data_pair[63:32];
         mem.mask  <= mask_pair[7:4];
      end
      if (state == lsu_pkg::DONE && r_load)
         r_odata <= ld_val;   // held until the next load completes
   end

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_x)
      $onehot0({mem.rd, mem.wr, mem.refresh}));

   // mask comes from the setup state before the strobe
   a_wr_mask: assert property (@(posedge clk) disable iff (!rst_x)
      mem.wr |-> mem.mask != '0);

endmodule

/* source/sdram_sequencer.sv */
`timescale 1ns/1ps

module sdram_sequencer (
   input  logic                        clk,
   input  logic                        rst_x,
   mem_if.responder                    mem,
   output logic                        o_init_done,
   output logic                        o_sdram_clk,
   output logic                        o_sdram_cke,
   output logic                        o_sdram_cs_n,
   output logic                        o_sdram_ras_n,
   output logic                        o_sdram_cas_n,
   output logic                        o_sdram_we_n,
   output logic [dram_pkg::ROW_W-1:0]  o_sdram_addr,
   output logic [dram_pkg::BANK_W-1:0] o_sdram_ba,
   output logic [dram_pkg::MASK_W-1:0] o_sdram_dqm,
   inout  wire  [dram_pkg::DQ_W-1:0]   io_sdram_dq
);

   dram_pkg::seq_state_e        state;
   dram_pkg::seq_state_e        nxt_state;   // target of S_WAIT
   dram_pkg::sdram_cmd_e        cmd;
   logic [7:0]                  dly_cnt;
   logic                        init_ref;    // first init refresh issued
   logic                        op_rd;
   logic                        rd_pend;
   logic                        dq_oe;
   logic                        cke;
   logic [dram_pkg::ROW_W-1:0]  sd_addr;
   logic [dram_pkg::BANK_W-1:0] sd_ba;
   logic [dram_pkg::MASK_W-1:0] dqm;

   assign o_sdram_clk  = clk;   // chip runs on the core clock
   assign o_sdram_cke  = cke;
   assign {o_sdram_cs_n, o_sdram_ras_n, o_sdram_cas_n, o_sdram_we_n} = cmd;
   assign o_sdram_addr = sd_addr;
   assign o_sdram_ba   = sd_ba;
   assign o_sdram_dqm  = dqm;

   // wdata is stable until busy falls
   assign io_sdram_dq = dq_oe ? mem.wdata : 'z;

   // next state acts cycles+2 clocks after the call
   task automatic wait_then(input int cycles, input dram_pkg::seq_state_e next);
      state     <= dram_pkg::S_WAIT;
      dly_cnt   <= 8'(cycles);
      nxt_state <= next;
   endtask

   always_ff @(posedge clk) begin
      if (!rst_x) begin
         state       <= dram_pkg::S_WAIT;
         nxt_state   <= dram_pkg::S_INIT_PRE;
         dly_cnt     <= 8'(dram_pkg::INIT_WAIT - 1);
         cmd         <= dram_pkg::NOP;
         cke         <= 1'b0;
         dqm         <= '1;
         dq_oe       <= 1'b0;
         init_ref    <= 1'b0;
         rd_pend     <= 1'b0;
         op_rd       <= 1'b0;
         o_init_done <= 1'b0;
         mem.busy    <= 1'b1;   // busy through init
      end else begin
         cke   <= 1'b1;
         cmd   <= dram_pkg::NOP;
         dq_oe <= 1'b0;
         dqm   <= '0;
         case (state)
            dram_pkg::S_WAIT: begin
               if (dly_cnt == 8'd0)
                  state <= nxt_state;
               else
                  dly_cnt <= dly_cnt - 1'b1;
            end
            dram_pkg::S_INIT_PRE: begin
               cmd     <= dram_pkg::PRECHARGE;
               sd_addr <= dram_pkg::A10;   // all banks
               wait_then(dram_pkg::T_RP - 1, dram_pkg::S_INIT_REF);
            end
            dram_pkg::S_INIT_REF: begin
               cmd      <= dram_pkg::REFRESH;
               init_ref <= 1'b1;
               wait_then(dram_pkg::T_RFC - 1,
                         init_ref ? dram_pkg::S_INIT_MODE : dram_pkg::S_INIT_REF);
            end
            dram_pkg::S_INIT_MODE: begin
               cmd         <= dram_pkg::LOAD_MODE;
               sd_addr     <= dram_pkg::MODE_REG;
               sd_ba       <= '0;
               o_init_done <= 1'b1;
               wait_then(0, dram_pkg::S_DONE);   // covers tMRD
            end
            dram_pkg::S_IDLE: begin
               if (mem.refresh) begin
                  cmd      <= dram_pkg::REFRESH;
                  mem.busy <= 1'b1;
                  wait_then(dram_pkg::T_RFC - 1, dram_pkg::S_DONE);
               end else if (mem.rd || mem.wr) begin
                  cmd      <= dram_pkg::ACTIVE;
                  sd_addr  <= mem.addr[dram_pkg::ROW_LSB-2 +: dram_pkg::ROW_W];
                  sd_ba    <= mem.addr[dram_pkg::BANK_LSB-2 +: dram_pkg::BANK_W];
                  op_rd    <= mem.rd;
                  mem.busy <= 1'b1;
                  wait_then(dram_pkg::T_RCD - 2, dram_pkg::S_RW);
               end
            end
            dram_pkg::S_RW: begin
               sd_addr <= dram_pkg::A10 |
                          dram_pkg::ROW_W'(mem.addr[dram_pkg::COL_LSB-2 +: dram_pkg::COL_W]);
               if (op_rd) begin
                  cmd     <= dram_pkg::READ;
                  rd_pend <= 1'b1;
                  wait_then(dram_pkg::CAS_LAT - 1, dram_pkg::S_CAPTURE);
               end else begin
                  cmd   <= dram_pkg::WRITE;
                  dq_oe <= 1'b1;          // one data beat
                  dqm   <= ~mem.mask;
                  wait_then(dram_pkg::T_WR + dram_pkg::T_RP, dram_pkg::S_DONE);
               end
            end
            dram_pkg::S_CAPTURE: begin
               mem.rdata <= io_sdram_dq;
               rd_pend   <= 1'b0;
               wait_then(dram_pkg::T_RP - 1, dram_pkg::S_DONE);   // auto-precharge
            end
            dram_pkg::S_DONE: begin
               mem.busy <= 1'b0;
               state    <= dram_pkg::S_IDLE;
            end
            default:
               state <= dram_pkg::S_IDLE;
         endcase
      end
   end

   a_no_dq_on_read: assert property (@(posedge clk) disable iff (!rst_x)
      rd_pend |-> !dq_oe);

   // only init commands before the mode register is loaded
   a_init_cmds: assert property (@(posedge clk) disable iff (!rst_x)
      !o_init_done |-> cmd inside {dram_pkg::NOP, dram_pkg::PRECHARGE,
                                  dram_pkg::REFRESH, dram_pkg::LOAD_MODE});

endmodule

/* source/dram_subsystem.sv */
`timescale 1ns/1ps

module dram_subsystem (
   input  logic                        clk,
   input  logic                        rst_x,
   input  logic                        i_rd_en,
   input  logic                        i_wr_en,
   input  logic [31:0]                 i_addr,
   input  logic [31:0]                 i_data,
   input  logic [lsu_pkg::CTRL_W-1:0]  i_ctrl,
   output logic [31:0]                 o_data,
   output logic                        o_busy,
   output logic                        o_init_done,
   output logic                        o_sdram_clk,
   output logic                        o_sdram_cke,
   output logic                        o_sdram_cs_n,
   output logic                        o_sdram_ras_n,
   output logic                        o_sdram_cas_n,
   output logic                        o_sdram_we_n,
   output logic [dram_pkg::ROW_W-1:0]  o_sdram_addr,
   output logic [dram_pkg::BANK_W-1:0] o_sdram_ba,
   output logic [dram_pkg::MASK_W-1:0] o_sdram_dqm,
   inout  wire  [dram_pkg::DQ_W-1:0]   io_sdram_dq
);

   logic stall;

   mem_if bus ();

   assign o_busy = stall | bus.busy;

   dram_access_ctrl u_ctrl (
      .clk     (clk),
      .rst_x   (rst_x),
      .i_rd_en (i_rd_en),
      .i_wr_en (i_wr_en),
      .i_addr  (i_addr),
      .i_data  (i_data),
      .i_ctrl  (i_ctrl),
      .o_data  (o_data),
      .o_stall (stall),
      .mem     (bus.requester)
   );

   sdram_sequencer u_seq (
      .clk           (clk),
      .rst_x         (rst_x),
      .mem           (bus.responder),
      .o_init_done   (o_init_done),
      .o_sdram_clk   (o_sdram_clk),
      .o_sdram_cke   (o_sdram_cke),
      .o_sdram_cs_n  (o_sdram_cs_n),
      .o_sdram_ras_n (o_sdram_ras_n),
      .o_sdram_cas_n (o_sdram_cas_n),
      .o_sdram_we_n  (o_sdram_we_n),
      .o_sdram_addr  (o_sdram_addr),
      .o_sdram_ba    (o_sdram_ba),
      .o_sdram_dqm   (o_sdram_dqm),
      .io_sdram_dq   (io_sdram_dq)
   );

endmodule

/* dv/sdram_model.sv */
`timescale 1ns/1ps

// single SDRAM chip, one 32-bit word per column
module sdram_model (
   input  logic                        i_clk,
   input  logic                        i_cke,
   input  logic                        i_cs_n,
   input  logic                        i_ras_n,
   input  logic                        i_cas_n,
   input  logic                        i_we_n,
   input  logic [dram_pkg::ROW_W-1:0]  i_addr,
   input  logic [dram_pkg::BANK_W-1:0] i_ba,
   input  logic [dram_pkg::MASK_W-1:0] i_dqm,
   inout  wire  [dram_pkg::DQ_W-1:0]   io_dq
);

   localparam int NUM_BANKS = 1 << dram_pkg::BANK_W;

   dram_pkg::sdram_cmd_e         cmd;
   logic [dram_pkg::DQ_W-1:0]    words [int];   // key {bank, row, col}
   logic [dram_pkg::ROW_W-1:0]   open_row [NUM_BANKS];
   logic                         row_open [NUM_BANKS];
   int                           act_cycle [NUM_BANKS];
   int                           cycle = 0;
   int                           refresh_cnt = 0;
   int                           errors = 0;
   logic [dram_pkg::DQ_W-1:0]    rd_word;
   logic [dram_pkg::CAS_LAT-1:0] rd_vld = '0;

   assign cmd   = dram_pkg::sdram_cmd_e'({i_cs_n, i_ras_n, i_cas_n, i_we_n});
   assign io_dq = rd_vld[dram_pkg::CAS_LAT-1] ? rd_word : 'z;   // CAS_LAT after READ

   always @(posedge i_clk) begin : decode
      int key;
      logic [dram_pkg::DQ_W-1:0] word;
      rd_vld <= {rd_vld[dram_pkg::CAS_LAT-2:0], i_cke === 1'b1 && cmd == dram_pkg::READ};
      if (i_cke === 1'b1) begin
         case (cmd)
            dram_pkg::ACTIVE: begin
               open_row[i_ba]  = i_addr;
               row_open[i_ba]  = 1'b1;
               act_cycle[i_ba] = cycle;
            end
            dram_pkg::READ, dram_pkg::WRITE: begin
               if (row_open[i_ba] !== 1'b1) begin
                  errors++;
                  $display("sdram model: read or write to a closed row in bank %0d", i_ba);
               end else begin
                  if (cycle - act_cycle[i_ba] < dram_pkg::T_RCD) begin
                     errors++;
                     $display("sdram model: only %0d cycles from activate to read or write",
                              cycle - act_cycle[i_ba]);
                  end
                  key  = int'({i_ba, open_row[i_ba], i_addr[dram_pkg::COL_W-1:0]});
                  word = words.exists(key) ? words[key] : '0;
                  if (cmd == dram_pkg::WRITE) begin
                     for (int b = 0; b < dram_pkg::MASK_W; b++)
                        if (!i_dqm[b]) word[8*b +: 8] = io_dq[8*b +: 8];   // dqm high skips
                     words[key] = word;
                  end
                  rd_word <= word;
                  if (i_addr[10]) row_open[i_ba] = 1'b0;   // auto-precharge
               end
            end
            dram_pkg::PRECHARGE: begin
               if (i_addr[10]) begin
                  for (int b = 0; b < NUM_BANKS; b++)
                     row_open[b] = 1'b0;
               end else begin
                  row_open[i_ba] = 1'b0;
               end
            end
            dram_pkg::REFRESH:
               refresh_cnt++;
            dram_pkg::LOAD_MODE: begin
               if (i_addr !== dram_pkg::MODE_REG) begin
                  errors++;
                  $display("sdram model: mode register loaded with %03h", i_addr);
               end
            end
            default: ;
         endcase
      end
      cycle++;
   end

endmodule

/* dv/tb_dram_subsystem.sv */
`timescale 1ns/1ps

module tb_dram_subsystem;

   localparam int RAND_SEED = 32'h6336_8f2b;
   localparam int NUM_OPS   = 8 + 24 + 24 + 60 + 4;   // accesses over all tests
   localparam int WATCHDOG  = NUM_OPS * 40 + dram_pkg::INIT_WAIT + 2000;

   logic                        clk = 1'b0;
   logic                        rst_x;
   logic                        i_rd_en;
   logic                        i_wr_en;
   logic [31:0]                 i_addr;
   logic [31:0]                 i_data;
   logic [lsu_pkg::CTRL_W-1:0]  i_ctrl;
   logic [31:0]                 o_data;
   logic                        o_busy;
   logic                        o_init_done;
   logic                        sd_clk;
   logic                        sd_cke;
   logic                        sd_cs_n;
   logic                        sd_ras_n;
   logic                        sd_cas_n;
   logic                        sd_we_n;
   logic [dram_pkg::ROW_W-1:0]  sd_addr;
   logic [dram_pkg::BANK_W-1:0] sd_ba;
   logic [dram_pkg::MASK_W-1:0] sd_dqm;
   wire  [dram_pkg::DQ_W-1:0]   sd_dq;
   logic [7:0]                  shadow [int];   // expected bytes by address
   int                          errors = 0;

   always #10 clk = ~clk;

   dram_subsystem uut (
      .clk (clk), .rst_x (rst_x), .i_rd_en (i_rd_en), .i_wr_en (i_wr_en),
      .i_addr (i_addr), .i_data (i_data), .i_ctrl (i_ctrl), .o_data (o_data),
      .o_busy (o_busy), .o_init_done (o_init_done), .o_sdram_clk (sd_clk),
      .o_sdram_cke (sd_cke), .o_sdram_cs_n (sd_cs_n), .o_sdram_ras_n (sd_ras_n),
      .o_sdram_cas_n (sd_cas_n), .o_sdram_we_n (sd_we_n), .o_sdram_addr (sd_addr),
      .o_sdram_ba (sd_ba), .o_sdram_dqm (sd_dqm), .io_sdram_dq (sd_dq)
   );

   sdram_model u_sdram (
      .i_clk (sd_clk), .i_cke (sd_cke), .i_cs_n (sd_cs_n), .i_ras_n (sd_ras_n),
      .i_cas_n (sd_cas_n), .i_we_n (sd_we_n), .i_addr (sd_addr), .i_ba (sd_ba),
      .i_dqm (sd_dqm), .io_dq (sd_dq)
   );

   task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("** Error %s: expected %08h, actual %08h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input int min_exp, input int act);
      if (act < min_exp) begin
         errors++;
         $display("** Error %s: expected at least %0d, actual %0d", name, min_exp, act);
      end
   endtask

   function automatic int size_bytes(input lsu_pkg::access_size_e size);
      case (size)
         lsu_pkg::SIZE_BYTE: return 1;
         lsu_pkg::SIZE_HALF: return 2;
         default:            return 4;
      endcase
   endfunction

   // little-endian bytes from the shadow with sign or zero extension
   function automatic logic [31:0] predict_load(input logic [31:0] addr,
                                                input lsu_pkg::access_size_e size,
                                                input logic uns);
      logic [31:0] val;
      int          n;
      val = '0;
      n   = size_bytes(size);
      for (int i = 0; i < n; i++)
         if (shadow.exists(addr + i)) val[8*i +: 8] = shadow[addr + i];
      if (!uns && n < 4 && val[8*n-1]) val = val | (32'hffff_ffff << (8 * n));
      return val;
   endfunction

   task automatic wait_ready();
      do begin
         @(posedge clk);
      end while (o_busy);
   endtask

   // request is taken on the edge that sees o_busy low
   task automatic run_access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                             input lsu_pkg::access_size_e size, input logic uns);
      i_rd_en <= !wr;
      i_wr_en <= wr;
      i_addr  <= addr;
      i_data  <= data;
      i_ctrl  <= {uns, size};   // unsigned flag above the size field
      wait_ready();
      i_rd_en <= 1'b0;
      i_wr_en <= 1'b0;
      wait_ready();             // end of access
   endtask

   task automatic store(input logic [31:0] addr, input logic [31:0] data,
                        input lsu_pkg::access_size_e size);
      for (int i = 0; i < size_bytes(size); i++)
         shadow[addr + i] = data[8*i +: 8];
      run_access(1'b1, addr, data, size, 1'b0);
   endtask

   task automatic load_check(input string name, input logic [31:0] addr,
                             input lsu_pkg::access_size_e size, input logic uns);
      logic [31:0] exp;
      exp = predict_load(addr, size, uns);
      run_access(1'b0, addr, 32'd0, size, uns);
      check_data(name, exp, o_data);
   endtask

   // one word in bank i at a row and column of its own
   function automatic logic [31:0] bank_word_addr(input int i);
      return (32'(i) << 21) | (32'(i * 37 + 1) << 10) | (32'(i * 5) << 2);
   endfunction

   task automatic test_init();
      int n;
      while (!o_init_done) @(posedge clk);
      n = 0;
      while (o_busy && n < 16) begin
         @(posedge clk);
         n++;
      end
      if (o_busy) begin
         errors++;
         $display("init: o_busy still high 16 cycles after o_init_done rose");
      end
   endtask

   task automatic test_aligned_word();
      for (int i = 0; i < 4; i++)
         store(bank_word_addr(i), $urandom, lsu_pkg::SIZE_WORD);
      for (int i = 0; i < 4; i++)
         load_check("aligned_word", bank_word_addr(i), lsu_pkg::SIZE_WORD, 1'b0);
   endtask

   task automatic test_byte_half_lanes();
      logic [31:0] base;
      base = 32'h0000_1000;
      store(base, 32'h1122_3344, lsu_pkg::SIZE_WORD);
      for (int i = 0; i < 4; i++)
         store(base + i, 32'hdead_be80 + 32'(i) * 32'h11, lsu_pkg::SIZE_BYTE);  // top bit set
      load_check("byte_half_lanes", base, lsu_pkg::SIZE_WORD, 1'b0);
      for (int i = 0; i < 4; i++) begin
         load_check("byte_half_lanes", base + i, lsu_pkg::SIZE_BYTE, 1'b0);
         load_check("byte_half_lanes", base + i, lsu_pkg::SIZE_BYTE, 1'b1);
      end
      store(base, 32'h5555_c5d6, lsu_pkg::SIZE_HALF);
      store(base + 1, 32'h5555_e7f8, lsu_pkg::SIZE_HALF);
      store(base + 2, 32'h5555_9a0b, lsu_pkg::SIZE_HALF);
      load_check("byte_half_lanes", base, lsu_pkg::SIZE_WORD, 1'b0);
      for (int i = 0; i < 3; i++) begin
         load_check("byte_half_lanes", base + i, lsu_pkg::SIZE_HALF, 1'b0);
         load_check("byte_half_lanes", base + i, lsu_pkg::SIZE_HALF, 1'b1);
      end
   endtask

   task automatic test_unaligned_split();
      logic [31:0] base;
      base = 32'h0000_2000;
      for (int i = 0; i < 8; i++)
         store(base + 4 * i, (base + 4 * i) ^ 32'h5a5a_a5a5, lsu_pkg::SIZE_WORD);
      store(base + 32'h01, 32'h8765_4321, lsu_pkg::SIZE_WORD);
      store(base + 32'h0a, 32'hfedc_ba98, lsu_pkg::SIZE_WORD);
      store(base + 32'h13, 32'h1357_9bdf, lsu_pkg::SIZE_WORD);
      store(base + 32'h1b, 32'h0000_f00d, lsu_pkg::SIZE_HALF);   // spills into next word
      load_check("unaligned_split", base + 32'h01, lsu_pkg::SIZE_WORD, 1'b0);
      load_check("unaligned_split", base + 32'h0a, lsu_pkg::SIZE_WORD, 1'b0);
      load_check("unaligned_split", base + 32'h13, lsu_pkg::SIZE_WORD, 1'b0);
      load_check("unaligned_split", base + 32'h1b, lsu_pkg::SIZE_HALF, 1'b0);
      for (int i = 0; i < 8; i++)   // neighbour bytes on both words
         load_check("unaligned_split", base + 4 * i, lsu_pkg::SIZE_WORD, 1'b0);
   endtask

   task automatic test_random_mix();
      logic [31:0]           addr;
      lsu_pkg::access_size_e size;
      for (int n = 0; n < 60; n++) begin
         addr = 32'h0001_0000 + ($urandom % 4093);   // 4 KB window
         size = lsu_pkg::access_size_e'(2'($urandom % 3));
         if ($urandom % 2)
            store(addr, $urandom, size);
         else
            load_check("random_mix", addr, size, 1'($urandom % 2));
      end
   endtask

   task automatic test_refresh_idle();
      int start;
      start = u_sdram.refresh_cnt;
      repeat (3 * dram_pkg::REFRESH_INTERVAL) @(posedge clk);
      check_count("refresh_idle", 2, u_sdram.refresh_cnt - start);
      for (int i = 0; i < 4; i++)
         load_check("refresh_idle", bank_word_addr(i), lsu_pkg::SIZE_WORD, 1'b0);
   endtask

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("watchdog: tests still running after %0d cycles, run stopped", WATCHDOG);
      $display("Regression failed");
      $finish;
   end

   initial begin
      void'($urandom(RAND_SEED));
      rst_x    = 1'b0;
      i_rd_en  = 1'b0;
      i_wr_en  = 1'b0;
      i_addr   = '0;
      i_data   = '0;
      i_ctrl   = '0;
      repeat (3) @(posedge clk);
      rst_x <= 1'b1;
      test_init();
      test_aligned_word();
      test_byte_half_lanes();
      test_unaligned_split();
      test_random_mix();
      test_refresh_idle();
      $display("errors: testbench %0d, sdram model %0d", errors, u_sdram.errors);
      if (errors == 0 && u_sdram.errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* project.f */
source/dram_pkg.sv
source/lsu_pkg.sv
source/mem_if.sv
source/dram_access_ctrl.sv
source/sdram_sequencer.sv
source/dram_subsystem.sv
dv/sdram_model.sv
dv/tb_dram_subsystem.sv

/* Bender.yml */
package:
  name: dram_subsystem

sources:
  - source/dram_pkg.sv
  - source/lsu_pkg.sv
  - source/mem_if.sv
  - source/dram_access_ctrl.sv
  - source/sdram_sequencer.sv
  - source/dram_subsystem.sv
  - target: test
    files:
      - dv/sdram_model.sv
      - dv/tb_dram_subsystem.sv
